// File: design/sdramPkg.sv
/* shared types and constants for the 68000 SDRAM controller
   command encodings, sequencer states, address widths and mode word */

package sdramPkg;

	//////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////

	localparam int CpuAddrBits = 32;	// 68000 address bus as seen by the controller
	localparam int RowBits = 13;	// 8192 rows
	localparam int ColBits = 10;	// 1024 columns
	localparam int BankBits = 2;	// 4 banks
	localparam int DataBits = 16;	// x16 device

	localparam int PowerCountBits = 16;	// power-up and CAS wait timer
	localparam int RefreshCountBits = 9;	// refresh interval timer

	// A10 selects all banks on precharge, auto-precharge on read/write
	localparam int PrechargeBit = 10;

	// CAS latency 2, burst length 1, single location writes
	localparam logic [RowBits-1:0] ModeWord = 13'h220;

	//////////////////////////////////////////////////
	// commands as {CKE, CS_L, RAS_L, CAS_L, WE_L}
	//////////////////////////////////////////////////

	typedef logic [4:0] sdramCmdT;

	localparam sdramCmdT cmdPowerUp = 5'b00000;	// CKE and CS low while powering up
	localparam sdramCmdT cmdNop = 5'b10111;
	localparam sdramCmdT cmdPrechargeAll = 5'b10010;	// needs A10 high
	localparam sdramCmdT cmdRefresh = 5'b10001;	// auto-refresh
	localparam sdramCmdT cmdActivate = 5'b10011;	// row on addr, bank on BA
	localparam sdramCmdT cmdReadAp = 5'b10101;	// column on addr, A10 high
	localparam sdramCmdT cmdWriteAp = 5'b10100;	// column on addr, A10 high
	localparam sdramCmdT cmdModeSet = 5'b10000;	// mode word on addr, BA zero

	//////////////////////////////////////////////////
	// sequencer states
	//////////////////////////////////////////////////

	typedef enum logic [4:0] {
		stInit,	// load power-up timer
		stPowerWait,	// hold CKE low until timer done
		stFirstNop,
		stPrecharge,	// precharge all before init refreshes
		stPrechargeNop,
		stInitRefresh,
		stInitRefreshNop,	// three NOPs after each init refresh
		stModeSet,
		stModeNop,
		stInitLoadTimer,	// first refresh interval
		stIdle,
		stRefPrecharge,	// periodic refresh sequence
		stRefNop,
		stRefresh,
		stRefNopCycle,
		stRefLoadTimer,
		stWriteDram,	// row open, waiting for data strobes
		stWriteWait,
		stReadDram,	// issue read with auto-precharge
		stReadWait,	// CAS latency, latch open
		stCpuWait	// hold dtack until strobes rise
	} seqStateT;

endpackage

// File: design/countdownTimer.sv
/* loadable down-counter with done flag, count type set by parameter */

`timescale 1ns/1ns

module countdownTimer #(
	parameter type CountT = logic [15:0]
) (
	input logic Clock,
	input logic Reset_L,
	input logic load,	// load on next clock
	input CountT loadValue,
	output logic done	// high while count is zero
);

	CountT count;

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			count <= CountT'(0);
		end else if (load) begin
			count <= loadValue;
		end else if (count != CountT'(0)) begin
			count <= count - CountT'(1);	// stops at zero
		end
	end

	assign done = (count == CountT'(0));

endmodule

// File: design/sdramSequencer.sv
/* command sequencer for SDRAM init, periodic refresh and 68000 accesses
   state register, init refresh counter and NOP counter */

`timescale 1ns/1ns

module sdramSequencer
	import sdramPkg::*;
#(
	parameter int PowerUpCycles = 5000,
	parameter int RefreshInterval = 375,
	parameter int InitRefreshes = 8,
	parameter int CasLatency = 2
) (
	input logic Clock,
	input logic Reset_L,
	input logic [CpuAddrBits-1:0] Address,
	input logic DramSelect_L,
	input logic AS_L,
	input logic WE_L,
	input logic UDS_L,
	input logic LDS_L,
	input logic powerDone,	// power/CAS timer at zero
	input logic refreshDue,	// refresh timer at zero
	output logic powerLoad,
	output logic [PowerCountBits-1:0] powerValue,
	output logic refreshLoad,
	output logic [RefreshCountBits-1:0] refreshValue,
	output sdramCmdT nextCmd,
	output logic [RowBits-1:0] nextAddr,
	output logic [BankBits-1:0] nextBank,
	output logic nextWriteEn,
	output logic nextLatchEn,
	output logic nextDtack_L,
	output logic nextResetOut_L
);

	localparam int RefCountBits = $clog2(InitRefreshes + 1);
	localparam logic [RowBits-1:0] PrechargeAllAddr = RowBits'(1) << PrechargeBit;

	seqStateT state;
	seqStateT nextState;
	logic [RefCountBits-1:0] refCount;	// init refreshes issued so far
	logic [2:0] nopCount;	// NOPs issued in the current wait state
	logic [RowBits-1:0] rowAddr;
	logic [RowBits-1:0] colAddr;
	logic [BankBits-1:0] cpuBank;
	logic strobeLow;	// either data strobe asserted

	//////////////////////////////////////////////////
	// address mapping
	//////////////////////////////////////////////////

	assign rowAddr = Address[ColBits+RowBits:ColBits+1];	// A23..A11
	assign cpuBank = Address[ColBits+RowBits+BankBits:ColBits+RowBits+1];	// A25..A24
	assign strobeLow = !UDS_L || !LDS_L;

	always_comb begin
		colAddr = '0;
		colAddr[ColBits-1:0] = Address[ColBits:1];	// word address, A0 unused
		colAddr[PrechargeBit] = 1'b1;	// auto-precharge
	end

	//////////////////////////////////////////////////
	// state and counters
	//////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			state <= stInit;
		end else begin
			state <= nextState;
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			refCount <= '0;
		end else if (state == stInitRefresh) begin
			refCount <= refCount + RefCountBits'(1);	// only counts during init
		end
	end

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			nopCount <= '0;
		end else if (state == stInitRefreshNop || state == stModeNop ||
				state == stRefNopCycle) begin
			nopCount <= nopCount + 3'd1;
		end else begin
			nopCount <= '0;	// fresh count on each entry
		end
	end

	//////////////////////////////////////////////////
	// next state and outputs
	//////////////////////////////////////////////////

	always_comb begin
		nextState = state;
		nextCmd = cmdNop;	// NOP unless a state says otherwise
		nextAddr = '0;
		nextBank = '0;
		nextWriteEn = 1'b0;
		nextLatchEn = 1'b0;
		nextDtack_L = 1'b1;
		nextResetOut_L = 1'b1;	// CPU runs once init is over
		powerLoad = 1'b0;
		powerValue = '0;
		refreshLoad = 1'b0;
		refreshValue = '0;

		case (state)
			stInit: begin
				nextCmd = cmdPowerUp;
				nextResetOut_L = 1'b0;
				powerLoad = 1'b1;
				powerValue = PowerCountBits'(PowerUpCycles);
				nextState = stPowerWait;
			end
			stPowerWait: begin
				nextCmd = cmdPowerUp;	// CKE stays low
				nextResetOut_L = 1'b0;
				if (powerDone) nextState = stFirstNop;
			end
			stFirstNop: begin
				nextResetOut_L = 1'b0;
				nextState = stPrecharge;
			end
			stPrecharge: begin
				nextCmd = cmdPrechargeAll;
				nextAddr = PrechargeAllAddr;
				nextResetOut_L = 1'b0;
				nextState = stPrechargeNop;
			end
			stPrechargeNop: begin
				nextResetOut_L = 1'b0;
				nextState = stInitRefresh;
			end
			stInitRefresh: begin
				nextCmd = cmdRefresh;
				nextResetOut_L = 1'b0;
				nextState = stInitRefreshNop;
			end
			stInitRefreshNop: begin
				nextResetOut_L = 1'b0;
				if (nopCount >= 3'd2) begin	// third NOP
					if (refCount < RefCountBits'(InitRefreshes)) nextState = stInitRefresh;
					else nextState = stModeSet;
				end
			end
			stModeSet: begin
				nextCmd = cmdModeSet;
				nextAddr = ModeWord;	// BA stays zero
				nextResetOut_L = 1'b0;
				nextState = stModeNop;
			end
			stModeNop: begin
				nextResetOut_L = 1'b0;
				if (nopCount >= 3'd2) nextState = stInitLoadTimer;
			end
			stInitLoadTimer: begin
				nextResetOut_L = 1'b0;
				refreshLoad = 1'b1;
				refreshValue = RefreshCountBits'(RefreshInterval);
				nextState = stIdle;
			end
			stIdle: begin
				if (refreshDue) begin	// refresh beats a new access
					nextState = stRefPrecharge;
				end else if (!DramSelect_L && !AS_L) begin
					nextCmd = cmdActivate;
					nextAddr = rowAddr;
					nextBank = cpuBank;
					nextState = WE_L ? stReadDram : stWriteDram;
				end
			end
			stRefPrecharge: begin
				nextCmd = cmdPrechargeAll;
				nextAddr = PrechargeAllAddr;
				nextState = stRefNop;
			end
			stRefNop: nextState = stRefresh;
			stRefresh: begin
				nextCmd = cmdRefresh;
				nextState = stRefNopCycle;
			end
			stRefNopCycle: begin
				if (nopCount >= 3'd2) nextState = stRefLoadTimer;	// fourth NOP follows
			end
			stRefLoadTimer: begin
				refreshLoad = 1'b1;
				refreshValue = RefreshCountBits'(RefreshInterval);
				nextState = stIdle;
			end
			stWriteDram: begin
				if (strobeLow) begin	// CPU data now valid
					nextCmd = cmdWriteAp;
					nextAddr = colAddr;
					nextBank = cpuBank;
					nextWriteEn = 1'b1;
					nextDtack_L = 1'b0;
					nextState = stWriteWait;
				end
			end
			stWriteWait: begin
				nextWriteEn = 1'b1;	// hold data one more cycle
				nextDtack_L = 1'b0;
				nextState = stCpuWait;
			end
			stReadDram: begin
				nextCmd = cmdReadAp;
				nextAddr = colAddr;
				nextBank = cpuBank;
				powerLoad = 1'b1;	// reuse power timer for CAS wait
				powerValue = PowerCountBits'(CasLatency - 1);
				nextState = stReadWait;
			end
			stReadWait: begin
				nextLatchEn = 1'b1;
				nextDtack_L = 1'b0;
				if (powerDone) nextState = stCpuWait;
			end
			stCpuWait: begin
				if (strobeLow) nextDtack_L = 1'b0;	// bus cycle still running
				else nextState = stIdle;
			end
			default: nextState = stInit;
		endcase
	end

endmodule

// File: design/sdramPins.sv
/* pin stage, registers command, address and bus controls
   DQ tri-state and falling-edge read data latch */

`timescale 1ns/1ns

module sdramPins
	import sdramPkg::*;
(
	input logic Clock,
	input logic Reset_L,
	input sdramCmdT nextCmd,
	input logic [RowBits-1:0] nextAddr,
	input logic [BankBits-1:0] nextBank,
	input logic nextWriteEn,
	input logic nextLatchEn,
	input logic nextDtack_L,
	input logic nextResetOut_L,
	input logic [DataBits-1:0] DataIn,	// write data from the 68000
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output logic [RowBits-1:0] SDram_Addr,
	output logic [BankBits-1:0] SDram_BA,
	output logic Dtack_L,
	output logic ResetOut_L,
	output logic [DataBits-1:0] DataOut,	// read data to the 68000
	inout wire [DataBits-1:0] SDram_DQ
);

	logic writeEn;	// drive DQ this cycle
	logic latchEn;	// capture DQ on falling edges

	always_ff @(posedge Clock or negedge Reset_L) begin
		if (!Reset_L) begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= cmdPowerUp;
			writeEn <= 1'b0;
			latchEn <= 1'b0;
			Dtack_L <= 1'b1;
			ResetOut_L <= 1'b0;	// hold CPU in reset during init
		end else begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= nextCmd;
			writeEn <= nextWriteEn;
			latchEn <= nextLatchEn;
			Dtack_L <= nextDtack_L;
			ResetOut_L <= nextResetOut_L;
		end
	end

	always_ff @(posedge Clock) begin
		SDram_Addr <= nextAddr;	// row, column or mode word
		SDram_BA <= nextBank;
	end

	assign SDram_DQ = writeEn ? DataIn : 'z;	// released for reads

	always_ff @(negedge Clock) begin
		if (latchEn) DataOut <= SDram_DQ;	// mid-cycle sample of read data
	end

endmodule

// File: design/m68kSdramController.sv
/* top level of the 68000 SDRAM controller
   power/CAS timer, refresh timer, command sequencer and pin stage */

`timescale 1ns/1ns

module m68kSdramController
	import sdramPkg::*;
#(
	parameter int PowerUpCycles = 5000,	// 100us at 50MHz
	parameter int RefreshInterval = 375,	// 7.5us at 50MHz
	parameter int InitRefreshes = 8,
	parameter int CasLatency = 2
) (
	input logic Clock,
	input logic Reset_L,
	input logic [CpuAddrBits-1:0] Address,
	input logic [DataBits-1:0] DataIn,
	input logic UDS_L,	// upper data strobe
	input logic LDS_L,	// lower data strobe
	input logic DramSelect_L,	// address decoder hit
	input logic WE_L,	// low for write
	input logic AS_L,	// address strobe
	output logic [DataBits-1:0] DataOut,
	output logic SDram_CKE_H,
	output logic SDram_CS_L,
	output logic SDram_RAS_L,
	output logic SDram_CAS_L,
	output logic SDram_WE_L,
	output logic [RowBits-1:0] SDram_Addr,
	output logic [BankBits-1:0] SDram_BA,
	inout wire [DataBits-1:0] SDram_DQ,
	output logic Dtack_L,
	output logic ResetOut_L
);

	logic powerLoad;
	logic [PowerCountBits-1:0] powerValue;
	logic powerDone;
	logic refreshLoad;
	logic [RefreshCountBits-1:0] refreshValue;
	logic refreshDue;
	sdramCmdT nextCmd;
	logic [RowBits-1:0] nextAddr;
	logic [BankBits-1:0] nextBank;
	logic nextWriteEn;
	logic nextLatchEn;
	logic nextDtack_L;
	logic nextResetOut_L;

	//////////////////////////////////////////////////
	// timers
	//////////////////////////////////////////////////

	countdownTimer #(.CountT(logic [PowerCountBits-1:0])) powerTimer (
		.Clock(Clock), .Reset_L(Reset_L),
		.load(powerLoad), .loadValue(powerValue), .done(powerDone)
	);

	countdownTimer #(.CountT(logic [RefreshCountBits-1:0])) refreshTimer (
		.Clock(Clock), .Reset_L(Reset_L),
		.load(refreshLoad), .loadValue(refreshValue), .done(refreshDue)
	);

	//////////////////////////////////////////////////
	// sequencer and pins
	//////////////////////////////////////////////////

	sdramSequencer #(
		.PowerUpCycles(PowerUpCycles), .RefreshInterval(RefreshInterval),
		.InitRefreshes(InitRefreshes), .CasLatency(CasLatency)
	) seq (
		.Clock(Clock), .Reset_L(Reset_L), .Address(Address),
		.DramSelect_L(DramSelect_L), .AS_L(AS_L), .WE_L(WE_L), .UDS_L(UDS_L), .LDS_L(LDS_L),
		.powerDone(powerDone), .refreshDue(refreshDue),
		.powerLoad(powerLoad), .powerValue(powerValue),
		.refreshLoad(refreshLoad), .refreshValue(refreshValue),
		.nextCmd(nextCmd), .nextAddr(nextAddr), .nextBank(nextBank),
		.nextWriteEn(nextWriteEn), .nextLatchEn(nextLatchEn),
		.nextDtack_L(nextDtack_L), .nextResetOut_L(nextResetOut_L)
	);

	sdramPins pins (
		.Clock(Clock), .Reset_L(Reset_L),
		.nextCmd(nextCmd), .nextAddr(nextAddr), .nextBank(nextBank),
		.nextWriteEn(nextWriteEn), .nextLatchEn(nextLatchEn),
		.nextDtack_L(nextDtack_L), .nextResetOut_L(nextResetOut_L), .DataIn(DataIn),
		.SDram_CKE_H(SDram_CKE_H), .SDram_CS_L(SDram_CS_L), .SDram_RAS_L(SDram_RAS_L),
		.SDram_CAS_L(SDram_CAS_L), .SDram_WE_L(SDram_WE_L),
		.SDram_Addr(SDram_Addr), .SDram_BA(SDram_BA),
		.Dtack_L(Dtack_L), .ResetOut_L(ResetOut_L), .DataOut(DataOut), .SDram_DQ(SDram_DQ)
	);

endmodule

// File: test/sdramModel.sv
/* behavioural x16 SDRAM for the controller testbench
   decodes pin commands, checks init and refresh order, stores words */

`timescale 1ns/1ns

module sdramModel
	import sdramPkg::*;
#(
	parameter int PowerUpCycles = 5000,
	parameter int InitRefreshes = 8
) (
	input logic Clock,
	input logic CKE, input logic CS_L, input logic RAS_L, input logic CAS_L, input logic WE_L,
	input logic [RowBits-1:0] Addr,
	input logic [BankBits-1:0] BA,
	inout wire [DataBits-1:0] DQ,
	input logic [31:0] cpuAddress,	// address the testbench is driving
	output logic initDone,	// mode register loaded
	output int refreshCount,	// auto-refreshes after init
	output int accessCount,	// activates seen
	output logic fault
);

	logic [DataBits-1:0] mem [int];
	logic [DataBits-1:0] readData;
	logic driveDq;
	logic [RowBits-1:0] openRow [4];
	logic openValid [4];
	sdramCmdT cmd;
	sdramCmdT lastCmd;	// last command other than NOP
	int powerUpCount, initRefreshCount, nopRun, readLeft, key;
	logic started, initPrecharged;

	assign DQ = driveDq ? readData : 'z;

	task automatic flag(input string msg);
		$display("SDRAM model: %s at %0t", msg, $time);
		fault = 1'b1;
	endtask

	initial begin
		{fault, initDone, started, initPrecharged, driveDq} = '0;
		{powerUpCount, initRefreshCount, refreshCount, accessCount, readLeft} = '0;
		nopRun = 100;
		lastCmd = cmdNop;
		for (int b = 0; b < 4; b++) openValid[b] = 1'b0;
	end

	always @(posedge Clock) begin
		cmd = {CKE, CS_L, RAS_L, CAS_L, WE_L};
		if (!started && $isunknown(cmd)) cmd = cmdPowerUp;	// pins not yet out of reset
		if (readLeft > 0) readLeft--;	// CAS latency pipeline
		if (cmd != cmdPowerUp && !started) begin
			started = 1'b1;
			if (powerUpCount < PowerUpCycles) flag("power-up wait too short");
		end
		if (cmd != cmdNop && cmd != cmdPowerUp && lastCmd == cmdRefresh && nopRun < 3)
			flag("fewer than three NOPs after auto-refresh");
		case (cmd)
			cmdPowerUp: begin
				if (started) flag("CKE dropped after power-up");
				powerUpCount++;
			end
			cmdNop: nopRun++;
			cmdPrechargeAll: begin
				if (!Addr[PrechargeBit]) flag("precharge without A10 set");
				initPrecharged = 1'b1;
				for (int b = 0; b < 4; b++) openValid[b] = 1'b0;
			end
			cmdRefresh: begin
				if (initDone && lastCmd != cmdPrechargeAll) flag("refresh not preceded by precharge-all");
				if (!initDone && !initPrecharged) flag("init refresh before precharge-all");
				if (initDone) refreshCount++;
				else initRefreshCount++;
				nopRun = 0;
			end
			cmdModeSet: begin
				if (Addr != ModeWord || BA != '0) flag("mode set with wrong mode word");
				if (initRefreshCount != InitRefreshes) flag("wrong number of init refreshes");
				initDone = 1'b1;
			end
			cmdActivate: begin
				if (!initDone) flag("activate before init finished");
				if (Addr != cpuAddress[23:11] || BA != cpuAddress[25:24])
					flag("activate row or bank does not match CPU address");
				openRow[BA] = Addr;
				openValid[BA] = 1'b1;
				accessCount++;
			end
			cmdReadAp, cmdWriteAp: begin
				if (!openValid[BA]) flag("column access to a bank with no open row");
				if (!Addr[PrechargeBit]) flag("column access without auto-precharge");
				if (Addr[9:0] != cpuAddress[10:1] || BA != cpuAddress[25:24])
					flag("column or bank does not match CPU address");
				key = {BA, openRow[BA], Addr[9:0]};
				if (cmd == cmdWriteAp) begin
					mem[key] = DQ;	// DQ still driven by the controller
				end else begin
					readData <= mem.exists(key) ? mem[key] : '0;
					readLeft = 2;
				end
				openValid[BA] = 1'b0;	// auto-precharge closes the row
			end
			default: flag("unknown command on the pins");
		endcase
		if (cmd != cmdNop && cmd != cmdPowerUp) lastCmd = cmd;
		driveDq <= (readLeft > 0);
	end

endmodule

// File: test/tbM68kSdramController.sv
/* testbench for the 68000 SDRAM controller
   clock, reset, bus tasks, reference function, compare task and watchdog */

`timescale 1ns/1ns

module tbM68kSdramController
	import sdramPkg::*;
;
	localparam int PowerUpCycles = 40;
	localparam int RefreshInterval = 120;
	localparam int InitRefreshes = 8;
	localparam int CasLatency = 2;
	localparam int InitCycles = 10 + PowerUpCycles + InitRefreshes * 5 + 20;
	localparam int TimeoutCycles = InitCycles + 200 * RefreshInterval;
	localparam int RefreshWindow = 1200;

	logic Clock, Reset_L, UDS_L, LDS_L, DramSelect_L, WE_L, AS_L;
	logic [31:0] Address;
	logic [DataBits-1:0] DataIn, DataOut;
	logic SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L;
	logic [RowBits-1:0] SDram_Addr;
	logic [BankBits-1:0] SDram_BA;
	wire [DataBits-1:0] SDram_DQ;
	logic Dtack_L, ResetOut_L, initDone, fault;
	int refreshCount, accessCount;
	logic [DataBits-1:0] shadow [int];	// past writes by bank, row and column
	logic [31:0] readAddrQ [$];
	logic [DataBits-1:0] readDataQ [$];
	event readDone;

	m68kSdramController #(
		.PowerUpCycles(PowerUpCycles), .RefreshInterval(RefreshInterval),
		.InitRefreshes(InitRefreshes), .CasLatency(CasLatency)
	) dut (.*);

	sdramModel #(.PowerUpCycles(PowerUpCycles), .InitRefreshes(InitRefreshes)) model (
		.Clock(Clock), .CKE(SDram_CKE_H), .CS_L(SDram_CS_L), .RAS_L(SDram_RAS_L),
		.CAS_L(SDram_CAS_L), .WE_L(SDram_WE_L), .Addr(SDram_Addr), .BA(SDram_BA),
		.DQ(SDram_DQ), .cpuAddress(Address), .initDone(initDone),
		.refreshCount(refreshCount), .accessCount(accessCount), .fault(fault)
	);

	initial begin
		Clock = 1'b0;
		forever #50 Clock = ~Clock;	// 100 ns period
	end

	function automatic int wordKey(input logic [31:0] addr);
		return {addr[25:24], addr[23:11], addr[10:1]};	// bank, row, column
	endfunction

	function automatic logic [DataBits-1:0] expectedWord(input logic [31:0] addr);
		return shadow.exists(wordKey(addr)) ? shadow[wordKey(addr)] : '0;
	endfunction

	task automatic stopWithFailure();
		$display("ERRORS FOUND");
		$fatal(1);
	endtask

	task automatic checkEqual(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %s got %h expected %h at %0t", name, got, exp, $time);
			stopWithFailure();
		end
	endtask

	// strobes held low after Dtack and no new access allowed meanwhile
	task automatic holdStrobes(input int cycles);
		int accessesBefore;
		accessesBefore = accessCount;
		repeat (cycles) begin
			@(negedge Clock);
			checkEqual("Dtack_L", Dtack_L, 0);
		end
		checkEqual("accessCount", accessCount, accessesBefore);
	endtask

	task automatic endCycle();
		{UDS_L, LDS_L, AS_L, DramSelect_L, WE_L} = 5'b11111;
		while (!Dtack_L) @(negedge Clock);	// Dtack returns high
	endtask

	task automatic writeWord(input logic [31:0] addr, input logic [DataBits-1:0] data,
			input int hold);
		@(negedge Clock);
		Address = addr;
		DataIn = data;
		{UDS_L, LDS_L, AS_L, DramSelect_L, WE_L} = 5'b00000;
		do @(negedge Clock); while (Dtack_L);
		holdStrobes(hold);
		endCycle();
		shadow[wordKey(addr)] = data;
	endtask

	task automatic readWord(input logic [31:0] addr, input int hold);
		logic [DataBits-1:0] got;
		@(negedge Clock);
		Address = addr;
		{UDS_L, LDS_L, AS_L, DramSelect_L, WE_L} = 5'b00001;
		do @(negedge Clock); while (Dtack_L);
		@(negedge Clock);
		got = DataOut;	// latched on the previous falling edge
		holdStrobes(hold);
		endCycle();
		readAddrQ.push_back(addr);
		readDataQ.push_back(got);
		->readDone;
	endtask

	initial begin : readCompare
		logic [31:0] addr;
		forever begin
			@(readDone);
			while (readAddrQ.size() > 0) begin
				addr = readAddrQ.pop_front();
				checkEqual("DataOut", readDataQ.pop_front(), expectedWord(addr));
			end
		end
	end

	initial begin
		wait (fault === 1'b1);
		$display("protocol violation reported by the SDRAM model");
		stopWithFailure();
	end

	initial begin
		repeat (TimeoutCycles) @(posedge Clock);
		$display("timeout: run did not finish within %0d clock cycles", TimeoutCycles);
		stopWithFailure();
	end

	initial begin : stimulus
		logic [31:0] pool [16];
		int refreshesBefore;
		{UDS_L, LDS_L, AS_L, DramSelect_L, WE_L} = 5'b11111;
		Address = '0;
		DataIn = '0;
		Reset_L = 1'b0;
		void'($urandom(32'hfacf));
		repeat (10) @(negedge Clock);
		Reset_L = 1'b1;

		while (!ResetOut_L) @(negedge Clock);	// init sequence
		checkEqual("initDone", initDone, 1);

		writeWord(32'h0123_4566, 16'hbeef, 0);
		readWord(32'h0123_4566, 0);

		refreshesBefore = refreshCount;	// idle bus
		repeat (RefreshWindow) @(negedge Clock);
		checkEqual("refreshCount",
			(refreshCount - refreshesBefore) >= RefreshWindow / (RefreshInterval + 10), 1);

		writeWord(32'h02ab_cd02, 16'h5a5a, 20);
		readWord(32'h02ab_cd02, 20);

		for (int i = 0; i < 16; i++) pool[i] = $urandom & 32'h03ff_fffe;
		repeat (200) begin
			if ($urandom % 2) writeWord(pool[$urandom % 16], 16'($urandom), 0);
			else readWord(pool[$urandom % 16], 0);
			repeat ($urandom % 150) @(negedge Clock);	// gap lets refresh collide
		end

		repeat (2) @(negedge Clock);
		if (fault !== 1'b1) begin
			$display("NO ERRORS");
			$finish;
		end else begin
			stopWithFailure();
		end
	end

endmodule

// File: sources.f
design/sdramPkg.sv
design/countdownTimer.sv
design/sdramSequencer.sv
design/sdramPins.sv
design/m68kSdramController.sv
test/sdramModel.sv
test/tbM68kSdramController.sv
